// ==== run.sh ====
#!/bin/sh
# Build and run from the project root, the hex path is relative to it
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/1ps --top-module cpuTb -f verilog.f -o cpuSim &&
./obj_dir/cpuSim | tee /dev/stderr | grep -q "All tests passed" ||
{ echo "Simulation did not pass"; exit 1; }

// ==== verif/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;

  // Byte addresses where the blocks of program.hex start
  localparam logic [15:0] memBlockPc    = 16'd20;
  localparam logic [15:0] branchBlockPc = 16'd40;
  localparam int          maxCycles     = 1000;  // Halt has to show up before this
  localparam int          maxCommits    = 128;

  logic           clk;
  logic           rstN;
  logic           hlt;
  cpuPkg::wordT   pc;
  logic           commitValid;
  cpuPkg::regIdxT commitReg;
  cpuPkg::wordT   commitData;

  cpuPkg::wordT   progMem [cpuPkg::iMemWords];
  cpuPkg::wordT   refMem  [cpuPkg::dMemWords];
  cpuPkg::wordT   refRegs [cpuPkg::regCount];
  cpuPkg::regIdxT expReg  [maxCommits];
  cpuPkg::wordT   expData [maxCommits];
  int             expTest [maxCommits];  // Test number of each commit
  int             expN;
  int             commitIdx;
  int             testErr  [1:5];
  bit             reported [1:5];
  int             testsFailed;

  cpu i_cpu (.clk, .rstN, .hlt, .pc, .commitValid, .commitReg, .commitData);

  always #4 clk = ~clk;

  function automatic string testName(input int t);
    case (t)
      1:       return "reset state";
      2:       return "ALU and forwarding";
      3:       return "memory and load-use";
      4:       return "branches and PCS";
      default: return "halt";
    endcase
  endfunction

  task automatic reportTest(input int t);
    reported[t] = 1'b1;
    if (testErr[t] == 0) begin
      $display("Test %0d (%s): ok", t, testName(t));
    end else begin
      testsFailed++;
      $display("Test %0d (%s): FAILED with %0d errors", t, testName(t), testErr[t]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // ISA reference model
  ////////////////////////////////////////////////////////////
  function automatic logic branchCond(input logic [2:0] cc, input logic z, input logic n,
                                      input logic v);
    case (cc)
      3'd0:    return !z;        // NE
      3'd1:    return z;         // EQ
      3'd2:    return !(z || n); // GT
      3'd3:    return n;         // LT
      3'd4:    return z || !n;   // GE
      3'd5:    return z || n;    // LE
      3'd6:    return v;
      default: return 1'b1;
    endcase
  endfunction

  // Writes to r0 vanish and never show as a commit
  task automatic recordCommit(input cpuPkg::regIdxT rd, input cpuPkg::wordT data,
                              input cpuPkg::wordT at);
    if (rd != '0 && expN < maxCommits) begin
      refRegs[rd]   = data;
      expReg[expN]  = rd;
      expData[expN] = data;
      expTest[expN] = at < memBlockPc ? 2 : at < branchBlockPc ? 3 : 4;
      expN++;
    end
  endtask

  task automatic runModel();
    cpuPkg::wordT mpc;
    cpuPkg::wordT ir;
    cpuPkg::wordT a;
    cpuPkg::wordT b;
    cpuPkg::wordT r;
    cpuPkg::wordT addr;
    logic [16:0]  wide;
    logic         z;
    logic         n;
    logic         v;
    logic         jump;
    bit           done;
    int           steps;
    mpc   = '0;
    {z, n, v} = 3'b000;
    done  = 1'b0;
    steps = 0;
    expN  = 0;
    for (int i = 0; i < cpuPkg::regCount; i++) refRegs[i] = '0;
    for (int i = 0; i < cpuPkg::dMemWords; i++) refMem[i] = '0;
    while (!done && steps < maxCycles) begin
      ir   = progMem[mpc[8:1]];
      a    = refRegs[ir[7:4]];
      b    = refRegs[ir[3:0]];
      addr = a + {{11{ir[3]}}, ir[3:0], 1'b0};
      jump = 1'b0;
      case (ir[15:12])
        4'h0, 4'h1: begin
          // One extra bit keeps the true sign, overflow when it disagrees
          wide = ir[12] ? {a[15], a} - {b[15], b} : {a[15], a} + {b[15], b};
          z    = wide[15:0] == '0;
          n    = wide[15];
          v    = wide[16] != wide[15];
          recordCommit(ir[11:8], wide[15:0], mpc);
        end
        4'h2, 4'h3: begin
          r = ir[12] ? (a & b) : (a ^ b);
          z = r == '0;  // N and V untouched
          recordCommit(ir[11:8], r, mpc);
        end
        4'hA: recordCommit(ir[11:8], {{8{ir[7]}}, ir[7:0]}, mpc);
        4'h8: recordCommit(ir[11:8], refMem[addr[8:1]], mpc);
        4'h9: refMem[addr[8:1]] = refRegs[ir[11:8]];
        4'hC: jump = branchCond(ir[11:9], z, n, v);
        4'hE: recordCommit(ir[11:8], mpc + 16'd2, mpc);
        4'hF: done = 1'b1;
        default: ;
      endcase
      mpc = jump ? mpc + 16'd2 + {{6{ir[8]}}, ir[8:0], 1'b0} : mpc + 16'd2;
      steps++;
    end
  endtask

  task automatic checkResetState(input string when);
    assert (pc == '0 && !hlt && !commitValid) else begin
      $display("[ERROR] %0t: %s pc=%h hlt=%b commitValid=%b, expected all zero",
               $time, when, pc, hlt, commitValid);
      testErr[1]++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Commit trace against the model, sampled mid-cycle
  ////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    int testNum;
    if (rstN && commitValid) begin
      assert (commitIdx < expN) else begin
        $display("[ERROR] %0t: extra commit r%0d=%h past the model's end",
                 $time, commitReg, commitData);
        testErr[5]++;
      end
      if (commitIdx < expN) begin
        testNum = expTest[commitIdx];
        assert (commitReg == expReg[commitIdx] && commitData == expData[commitIdx]) else begin
          $display("[ERROR] %0t: commit %0d wrote r%0d=%h, expected r%0d=%h", $time,
                   commitIdx, commitReg, commitData, expReg[commitIdx], expData[commitIdx]);
          testErr[testNum]++;
        end
        commitIdx++;
        if (commitIdx == expN || expTest[commitIdx] != testNum) reportTest(testNum);
      end
    end
  end

  initial begin
    int           cycles;
    int           errTotal;
    cpuPkg::wordT heldPc;
    clk         = 1'b0;
    rstN        = 1'b0;
    commitIdx   = 0;
    testsFailed = 0;
    errTotal    = 0;
    for (int t = 1; t <= 5; t++) begin
      testErr[t]  = 0;
      reported[t] = 1'b0;
    end
    $readmemh("verif/program.hex", progMem);
    runModel();

    @(negedge clk);
    checkResetState("during reset");
    @(posedge clk);  // Second rising edge under reset
    #1 rstN = 1'b1;
    @(negedge clk);
    checkResetState("first cycle after reset");
    reportTest(1);

    cycles = 0;
    while (!hlt && cycles < maxCycles) begin
      @(negedge clk);
      cycles++;
    end
    if (!hlt) begin
      $display("Timeout: hlt did not rise within %0d cycles", maxCycles);
      $display("Some tests failed");
      $finish;
    end else begin
      for (int t = 2; t <= 4; t++) begin
        if (!reported[t]) begin
          $display("[ERROR] %0t: halted with commits of test %0d missing", $time, t);
          testErr[t]++;
          reportTest(t);
        end
      end
      assert (commitIdx == expN) else begin
        $display("[ERROR] %0t: %0d commits before halt, model expects %0d",
                 $time, commitIdx, expN);
        testErr[5]++;
      end
      heldPc = pc;
      for (int i = 0; i < 20; i++) begin
        @(negedge clk);
        assert (hlt && pc == heldPc) else begin
          $display("[ERROR] %0t: after halt hlt=%b pc=%h, expected hlt=1 pc=%h",
                   $time, hlt, pc, heldPc);
          testErr[5]++;
        end
      end
      @(posedge clk);  // Let the last trace check settle
      reportTest(5);
      for (int t = 1; t <= 5; t++) errTotal += testErr[t];
      $display("Tests run: 5, failed: %0d, errors: %0d", testsFailed, errTotal);
      if (testsFailed == 0) begin
        $display("All tests passed");
      end else begin
        $display("Some tests failed");
      end
      $finish;
    end
  end

endmodule

// ==== verif/program.hex ====
// One instruction word in hex per line, starting at byte address 0
// Words 0-9 ALU block, 10-19 load/store block, 20 onwards branch block
A105 // LLB r1, 5
A2FD // LLB r2, -3
0312 // ADD r3, r1, r2
1431 // SUB r4, r3, r1
3541 // AND r5, r4, r1
2654 // XOR r6, r5, r4
0011 // ADD r0, r1, r1
0706 // ADD r7, r0, r6
A87F // LLB r8, 0x7f
2988 // XOR r9, r8, r8
AA10 // LLB r10, 0x10
93A0 // SW r3, 0(r10)
8BA0 // LW r11, 0(r10)
0CB1 // ADD r12, r11, r1
96A1 // SW r6, 2(r10)
8DA1 // LW r13, 2(r10)
9DA2 // SW r13, 4(r10)
8EA2 // LW r14, 4(r10)
A218 // LLB r2, 0x18
8F2C // LW r15, -8(r2)
1111 // SUB r1, r1, r1
C201 // B EQ +1, taken
A355 // LLB r3, skipped
0488 // ADD r4, r8, r8
C201 // B EQ +1, not taken
C601 // B LT +1, not taken
A580 // LLB r5, -128
0658 // ADD r6, r5, r8
C601 // B LT +1, taken
A366 // LLB r3, skipped
0444 // ADD r4, r4, r4 (loop)
CC01 // B OVF +1
CEFD // B always -3
E700 // PCS r7
C801 // B GE +1, not taken
CA01 // B LE +1, taken
A377 // LLB r3, skipped
2977 // XOR r9, r7, r7
C401 // B GT +1, not taken
C601 // B LT +1, taken
A388 // LLB r3, skipped
F000 // HLT
A399 // LLB r3, never commits

// ==== verilog.f ====
verilog/cpuPkg.sv
verilog/pipeReg.sv
verilog/fetch.sv
verilog/decode.sv
verilog/hazardUnit.sv
verilog/execute.sv
verilog/dataMem.sv
verilog/cpu.sv
verif/cpuTb.sv

// ==== verilog/cpu.sv ====
`timescale 1ns/1ps

module cpu (
  input  logic           clk,
  input  logic           rstN,
  output logic           hlt,
  output cpuPkg::wordT   pc,
  output logic           commitValid,
  output cpuPkg::regIdxT commitReg,
  output cpuPkg::wordT   commitData
);

  cpuPkg::wordT    pcNext, instr, branchTarget;
  cpuPkg::ifIdT    ifIdD, ifIdQ;
  cpuPkg::idExT    decOut, idExQ;
  cpuPkg::exMemT   exMemD, exMemQ;
  cpuPkg::memWbT   memWbD, memWbQ;
  cpuPkg::regIdxT  srcA, srcB;
  logic            usesB, taken, isBranch;
  logic            pcStall, ifIdStall, ifFlush, idFlush;
  cpuPkg::wordT    exResult, storeData, memRdata, wbData;
  cpuPkg::flagsT   exFlags;
  cpuPkg::memCtrlT dCtrl;
  logic            stopped, wbWrite;

  // Halt seen in writeback, nothing behind it may change state
  assign stopped = hlt || memWbQ.wb.hlt;

  ////////////////////////////////////////////////////////////
  // Fetch and decode
  ////////////////////////////////////////////////////////////
  fetch iFetch (.clk, .rstN, .stall(pcStall), .halted(stopped), .redirect(taken),
                .target(branchTarget), .pc, .pcNext, .instr);

  assign ifIdD = '{instr: instr, pcNext: pcNext};
  pipeReg #(.payloadT(cpuPkg::ifIdT)) ifId (.clk, .rstN, .stall(ifIdStall), .flush(ifFlush),
                                             .d(ifIdD), .q(ifIdQ));

  decode iDecode (.clk, .rstN, .fetched(ifIdQ), .exFlags, .exZEn(idExQ.ex.zEn),
                  .exNvEn(idExQ.ex.nvEn), .wbWrite, .wbReg(memWbQ.wb.dest), .wbData,
                  .payload(decOut), .srcA, .srcB, .usesB, .taken, .target(branchTarget));

  assign isBranch = ifIdQ.instr[15:12] == cpuPkg::br;
  hazardUnit iHazard (.srcA, .srcB, .usesB, .isBranch, .isStore(decOut.mem.memWrite),
                      .idEx(idExQ), .taken, .pcStall, .ifIdStall, .ifFlush, .idFlush);

  pipeReg #(.payloadT(cpuPkg::idExT)) idEx (.clk, .rstN, .stall(1'b0), .flush(idFlush),
                                             .d(decOut), .q(idExQ));

  ////////////////////////////////////////////////////////////
  // Execute and memory
  ////////////////////////////////////////////////////////////
  execute iExecute (.stage(idExQ), .exMemResult(exMemQ.result), .exMemWb(exMemQ.wb),
                    .wbWrite, .wbReg(memWbQ.wb.dest), .wbData, .result(exResult),
                    .storeData, .flags(exFlags));

  assign exMemD = '{result: exResult, storeData: storeData, storeReg: idExQ.ex.srcB,
                    mem: idExQ.mem, wb: idExQ.wb, pcNext: idExQ.pcNext};
  pipeReg #(.payloadT(cpuPkg::exMemT)) exMem (.clk, .rstN, .stall(1'b0), .flush(1'b0),
                                               .d(exMemD), .q(exMemQ));

  assign dCtrl.memEnable = exMemQ.mem.memEnable;
  assign dCtrl.memWrite  = exMemQ.mem.memWrite && !stopped;  // No store past HLT
  dataMem iDataMem (.clk, .ctrl(dCtrl), .addr(exMemQ.result), .wdata(exMemQ.storeData),
                    .rdata(memRdata));

  assign memWbD = '{result: exMemQ.result, memData: memRdata, wb: exMemQ.wb,
                    pcNext: exMemQ.pcNext};
  pipeReg #(.payloadT(cpuPkg::memWbT)) memWb (.clk, .rstN, .stall(1'b0), .flush(1'b0),
                                               .d(memWbD), .q(memWbQ));

  ////////////////////////////////////////////////////////////
  // Writeback, commit trace and halt
  ////////////////////////////////////////////////////////////
  assign wbData = memWbQ.wb.memToReg ? memWbQ.memData :
                  memWbQ.wb.pcs      ? memWbQ.pcNext  : memWbQ.result;
  assign wbWrite = memWbQ.wb.regWrite && !stopped;

  assign commitValid = wbWrite;  // One commit per register write
  assign commitReg   = memWbQ.wb.dest;
  assign commitData  = wbData;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      hlt <= 1'b0;
    end else if (memWbQ.wb.hlt) begin
      hlt <= 1'b1;  // Sticky until reset
    end
  end

endmodule

// ==== verilog/cpuPkg.sv ====
package cpuPkg;

  ////////////////////////////////////////////////////////////
  // Widths and memory depths
  ////////////////////////////////////////////////////////////
  localparam int dataW     = 16;
  localparam int regCount  = 16;
  localparam int iMemWords = 256;
  localparam int dMemWords = 256;
  localparam int regIdxW   = $clog2(regCount);
  localparam int iAddrW    = $clog2(iMemWords);  // Word index into instruction memory
  localparam int dAddrW    = $clog2(dMemWords);

  typedef logic [dataW-1:0]   wordT;
  typedef logic [regIdxW-1:0] regIdxT;

  // Instruction formats, opcode always in [15:12]
  //   ALU    op rd rs rt
  //   LLB    op rd imm8       rd = sext(imm8)
  //   LW/SW  op rt rs off4    addr = rs + 2*sext(off4)
  //   B      op ccc off9      target = pc + 2 + 2*sext(off9)
  //   PCS    op rd xxxxxxxx   rd = pc + 2
  // An all-zero word is a bubble and does nothing
  typedef enum logic [3:0] {
    add   = 4'h0,
    sub   = 4'h1,
    xorOp = 4'h2,
    andOp = 4'h3,
    lw    = 4'h8,
    sw    = 4'h9,
    llb   = 4'hA,
    br    = 4'hC,
    pcs   = 4'hE,
    hlt   = 4'hF
  } opcodeT;

  typedef struct packed {
    logic z;
    logic n;
    logic v;
  } flagsT;

  ////////////////////////////////////////////////////////////
  // Control groups
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    regIdxT srcA;
    regIdxT srcB;
    wordT   opA;     // Register values as read in decode
    wordT   opB;
    wordT   imm;
    opcodeT aluSel;
    logic   useImm;  // Operand B from imm
    logic   zEn;
    logic   nvEn;
  } exCtrlT;

  typedef struct packed {
    logic memEnable;
    logic memWrite;
  } memCtrlT;

  typedef struct packed {
    regIdxT dest;
    logic   regWrite;
    logic   memToReg;
    logic   pcs;
    logic   hlt;
  } wbCtrlT;

  ////////////////////////////////////////////////////////////
  // Stage payloads
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    wordT instr;
    wordT pcNext;
  } ifIdT;

  typedef struct packed {
    exCtrlT  ex;
    memCtrlT mem;
    wbCtrlT  wb;
    wordT    pcNext;
  } idExT;

  typedef struct packed {
    wordT    result;     // ALU result, also the data address
    wordT    storeData;
    regIdxT  storeReg;
    memCtrlT mem;
    wbCtrlT  wb;
    wordT    pcNext;
  } exMemT;

  typedef struct packed {
    wordT   result;
    wordT   memData;
    wbCtrlT wb;
    wordT   pcNext;
  } memWbT;

endpackage

// ==== verilog/dataMem.sv ====
`timescale 1ns/1ps

module dataMem (
  input  logic            clk,
  input  cpuPkg::memCtrlT ctrl,
  input  cpuPkg::wordT    addr,   // Byte address
  input  cpuPkg::wordT    wdata,
  output cpuPkg::wordT    rdata
);

  cpuPkg::wordT mem [cpuPkg::dMemWords];

  initial begin
    for (int i = 0; i < cpuPkg::dMemWords; i++) begin
      mem[i] = '0;  // Starts cleared
    end
  end

  assign rdata = ctrl.memEnable ? mem[addr[cpuPkg::dAddrW:1]] : '0;

  always_ff @(posedge clk) begin
    if (ctrl.memEnable && ctrl.memWrite) mem[addr[cpuPkg::dAddrW:1]] <= wdata;
  end

endmodule

// ==== verilog/decode.sv ====
`timescale 1ns/1ps

module decode (
  input  logic           clk,
  input  logic           rstN,
  input  cpuPkg::ifIdT   fetched,
  input  cpuPkg::flagsT  exFlags,  // Flags computed in execute this cycle
  input  logic           exZEn,
  input  logic           exNvEn,
  input  logic           wbWrite,
  input  cpuPkg::regIdxT wbReg,
  input  cpuPkg::wordT   wbData,
  output cpuPkg::idExT   payload,
  output cpuPkg::regIdxT srcA,
  output cpuPkg::regIdxT srcB,
  output logic           usesB,    // ALU reads register B
  output logic           taken,
  output cpuPkg::wordT   target
);

  cpuPkg::wordT   regs [cpuPkg::regCount];
  cpuPkg::flagsT  flags;
  cpuPkg::opcodeT op;
  cpuPkg::wordT   instr;
  logic           condMet;

  assign instr = fetched.instr;
  assign op    = cpuPkg::opcodeT'(instr[15:12]);

  // Register read with write-through from writeback
  function automatic cpuPkg::wordT readReg(input cpuPkg::regIdxT r);
    if (r == '0) return '0;
    if (wbWrite && wbReg == r) return wbData;
    return regs[r];
  endfunction

  ////////////////////////////////////////////////////////////
  // Instruction decoder
  ////////////////////////////////////////////////////////////
  always_comb begin
    payload        = '0;
    payload.pcNext = fetched.pcNext;
    srcA           = '0;  // Unused sources stay at r0, never a hazard
    srcB           = '0;
    usesB          = 1'b0;
    if (instr != '0) begin
      payload.ex.aluSel = op;
      case (op)
        cpuPkg::add, cpuPkg::sub, cpuPkg::xorOp, cpuPkg::andOp: begin
          srcA            = instr[7:4];
          srcB            = instr[3:0];
          usesB           = 1'b1;
          payload.wb.dest = instr[11:8];
          payload.ex.zEn  = 1'b1;
          payload.ex.nvEn = (op == cpuPkg::add) || (op == cpuPkg::sub);
        end
        cpuPkg::llb: begin
          payload.wb.dest   = instr[11:8];
          payload.ex.imm    = {{8{instr[7]}}, instr[7:0]};
          payload.ex.useImm = 1'b1;
        end
        cpuPkg::lw, cpuPkg::sw: begin
          srcA                  = instr[7:4];  // Base
          payload.ex.imm        = {{11{instr[3]}}, instr[3:0], 1'b0};
          payload.ex.useImm     = 1'b1;
          payload.mem.memEnable = 1'b1;
          if (op == cpuPkg::sw) begin
            srcB                 = instr[11:8];  // Store data
            payload.mem.memWrite = 1'b1;
          end else begin
            payload.wb.dest     = instr[11:8];
            payload.wb.memToReg = 1'b1;
          end
        end
        cpuPkg::pcs: begin
          payload.wb.dest = instr[11:8];
          payload.wb.pcs  = 1'b1;
        end
        cpuPkg::hlt: payload.wb.hlt = 1'b1;
        default: ;  // B and unknown codes carry no work
      endcase
    end
    payload.wb.regWrite = payload.wb.dest != '0;  // Writes to r0 are dropped here
    payload.ex.srcA     = srcA;
    payload.ex.srcB     = srcB;
    payload.ex.opA      = readReg(srcA);
    payload.ex.opB      = readReg(srcB);
  end

  always_ff @(posedge clk) begin
    if (wbWrite && wbReg != '0) begin
      regs[wbReg] <= wbData;
    end
  end

  // Flag register, loaded from execute under the enables
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flags <= '0;
    end else begin
      if (exZEn) flags.z <= exFlags.z;
      if (exNvEn) begin
        flags.n <= exFlags.n;
        flags.v <= exFlags.v;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Branch resolution
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (instr[11:9])
      3'b000:  condMet = !flags.z;              // NE
      3'b001:  condMet = flags.z;               // EQ
      3'b010:  condMet = !flags.z && !flags.n;  // GT
      3'b011:  condMet = flags.n;               // LT
      3'b100:  condMet = flags.z || !flags.n;   // GE
      3'b101:  condMet = flags.n || flags.z;    // LE
      3'b110:  condMet = flags.v;               // Overflow
      default: condMet = 1'b1;                  // Always
    endcase
  end

  assign taken  = (op == cpuPkg::br) && condMet;
  assign target = fetched.pcNext + {{6{instr[8]}}, instr[8:0], 1'b0};

endmodule

// ==== verilog/execute.sv ====
`timescale 1ns/1ps

module execute (
  input  cpuPkg::idExT   stage,
  input  cpuPkg::wordT   exMemResult,
  input  cpuPkg::wbCtrlT exMemWb,
  input  logic           wbWrite,
  input  cpuPkg::regIdxT wbReg,
  input  cpuPkg::wordT   wbData,
  output cpuPkg::wordT   result,
  output cpuPkg::wordT   storeData,
  output cpuPkg::flagsT  flags
);

  cpuPkg::wordT a;
  cpuPkg::wordT regB;   // Forwarded register B, also the store data
  cpuPkg::wordT b;
  logic         ovf;

  // Newest producer wins, r0 never forwarded
  function automatic cpuPkg::wordT pick(input cpuPkg::regIdxT src,
                                        input cpuPkg::wordT decoded);
    if (src == '0) return decoded;
    if (exMemWb.regWrite && exMemWb.dest == src) return exMemResult;
    if (wbWrite && wbReg == src) return wbData;
    return decoded;
  endfunction

  ////////////////////////////////////////////////////////////
  // Operand select and ALU
  ////////////////////////////////////////////////////////////
  always_comb begin
    a    = pick(stage.ex.srcA, stage.ex.opA);
    regB = pick(stage.ex.srcB, stage.ex.opB);
    b    = stage.ex.useImm ? stage.ex.imm : regB;
    ovf  = 1'b0;
    case (stage.ex.aluSel)
      cpuPkg::add: begin
        result = a + b;
        ovf    = (a[15] == b[15]) && (result[15] != a[15]);
      end
      cpuPkg::sub: begin
        result = a - b;
        ovf    = (a[15] != b[15]) && (result[15] != a[15]);
      end
      cpuPkg::andOp:       result = a & b;
      cpuPkg::xorOp:       result = a ^ b;
      cpuPkg::llb:         result = b;             // Immediate already extended
      cpuPkg::lw, cpuPkg::sw: result = a + b;      // Effective address
      cpuPkg::pcs:         result = stage.pcNext;  // Lets PCS forward like any result
      default:             result = '0;
    endcase
  end

  assign storeData = regB;
  assign flags.z   = result == '0;
  assign flags.n   = result[cpuPkg::dataW-1];
  assign flags.v   = ovf;

endmodule

// ==== verilog/fetch.sv ====
`timescale 1ns/1ps

module fetch (
  input  logic         clk,
  input  logic         rstN,
  input  logic         stall,
  input  logic         halted,    // HLT reached writeback
  input  logic         redirect,  // Taken branch from decode
  input  cpuPkg::wordT target,
  output cpuPkg::wordT pc,
  output cpuPkg::wordT pcNext,
  output cpuPkg::wordT instr
);

  cpuPkg::wordT iMem [cpuPkg::iMemWords];

  // Unused words hold HLT so a run off the program end stops cleanly
  initial begin
    for (int i = 0; i < cpuPkg::iMemWords; i++) begin
      iMem[i] = {cpuPkg::hlt, 12'h000};
    end
    $readmemh("verif/program.hex", iMem);
  end

  assign pcNext = pc + 16'd2;
  assign instr  = iMem[pc[cpuPkg::iAddrW:1]];  // Byte address to word index

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= '0;
    end else if (!(stall || halted)) begin
      pc <= redirect ? target : pcNext;  // Static not-taken, fix up on redirect
    end
  end

endmodule

// ==== verilog/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit (
  input  cpuPkg::regIdxT srcA,
  input  cpuPkg::regIdxT srcB,
  input  logic           usesB,
  input  logic           isBranch,
  input  logic           isStore,
  input  cpuPkg::idExT   idEx,   // Instruction now in execute
  input  logic           taken,
  output logic           pcStall,
  output logic           ifIdStall,
  output logic           ifFlush,
  output logic           idFlush
);

  logic loadInEx;
  logic loadUse;
  logic flagWait;
  logic stall;

  assign loadInEx = idEx.mem.memEnable && !idEx.mem.memWrite && idEx.wb.regWrite;
  // Store data also counts, there is no memory to memory forwarding
  assign loadUse  = loadInEx && (idEx.wb.dest == srcA ||
                                 ((usesB || isStore) && idEx.wb.dest == srcB));
  assign flagWait = isBranch && (idEx.ex.zEn || idEx.ex.nvEn);  // Flags not yet in register
  assign stall    = loadUse || flagWait;

  assign pcStall   = stall;
  assign ifIdStall = stall;
  assign idFlush   = stall;           // Bubble into execute
  assign ifFlush   = taken && !stall; // Kill the wrong-path fetch

endmodule

// ==== verilog/pipeReg.sv ====
`timescale 1ns/1ps

// Stage register, all-zero payload is a bubble
module pipeReg #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    rstN,
  input  logic    stall,  // Hold current contents
  input  logic    flush,  // Replace with bubble
  input  payloadT d,
  output payloadT q
);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      q <= '0;
    end else if (stall) begin
      q <= q;
    end else if (flush) begin
      q <= '0;  // Every enable bit drops to zero
    end else begin
      q <= d;
    end
  end

endmodule
